//--- verilog/rsPkg.sv
package rsPkg;

        localparam int RS_ENTRIES = 6;
        localparam int LANES      = 3;
        localparam int TAG_W      = 4;

        typedef logic [TAG_W-1:0] tagT;

        typedef enum logic [1:0] {
                OP_ADD,
                OP_SUB,
                OP_MUL,
                OP_DIV
        } opT;

        typedef enum logic { HOLD_EMPTY, HOLD_FULL } holdStateT;

        typedef enum logic { LANE_IDLE, LANE_BUSY } laneStateT;

        // true when any completing lane broadcasts this tag.
        function automatic logic tagHit(tagT t, logic [LANES-1:0] v, tagT tags [LANES]);
                logic hit;
                hit = 1'b0;
                for (int l = 0; l < LANES; l++) begin
                        if (v[l] && tags[l] == t) begin
                                hit = 1'b1;
                        end
                end
                return hit;
        endfunction

endpackage

//--- verilog/slotCounters.sv
`timescale 1ns/1ps

// ********************
// zero count of the station occupancy mask
// ********************
module freeSlots6 (
        input  logic [5:0] emptyStatus,
        output logic [2:0] num
);
        always_comb begin
                case (emptyStatus)
                        6'd0:  num = 3'd6;
                        6'd1:  num = 3'd5;
                        6'd2:  num = 3'd5;
                        6'd3:  num = 3'd4;
                        6'd4:  num = 3'd5;
                        6'd5:  num = 3'd4;
                        6'd6:  num = 3'd4;
                        6'd7:  num = 3'd3;
                        6'd8:  num = 3'd5;
                        6'd9:  num = 3'd4;
                        6'd10: num = 3'd4;
                        6'd11: num = 3'd3;
                        6'd12: num = 3'd4;
                        6'd13: num = 3'd3;
                        6'd14: num = 3'd3;
                        6'd15: num = 3'd2;
                        6'd16: num = 3'd5;
                        6'd17: num = 3'd4;
                        6'd18: num = 3'd4;
                        6'd19: num = 3'd3;
                        6'd20: num = 3'd4;
                        6'd21: num = 3'd3;
                        6'd22: num = 3'd3;
                        6'd23: num = 3'd2;
                        6'd24: num = 3'd4;
                        6'd25: num = 3'd3;
                        6'd26: num = 3'd3;
                        6'd27: num = 3'd2;
                        6'd28: num = 3'd3;
                        6'd29: num = 3'd2;
                        6'd30: num = 3'd2;
                        6'd31: num = 3'd1;
                        6'd32: num = 3'd5;
                        6'd33: num = 3'd4;
                        6'd34: num = 3'd4;
                        6'd35: num = 3'd3;
                        6'd36: num = 3'd4;
                        6'd37: num = 3'd3;
                        6'd38: num = 3'd3;
                        6'd39: num = 3'd2;
                        6'd40: num = 3'd4;
                        6'd41: num = 3'd3;
                        6'd42: num = 3'd3;
                        6'd43: num = 3'd2;
                        6'd44: num = 3'd3;
                        6'd45: num = 3'd2;
                        6'd46: num = 3'd2;
                        6'd47: num = 3'd1;
                        6'd48: num = 3'd4;
                        6'd49: num = 3'd3;
                        6'd50: num = 3'd3;
                        6'd51: num = 3'd2;
                        6'd52: num = 3'd3;
                        6'd53: num = 3'd2;
                        6'd54: num = 3'd2;
                        6'd55: num = 3'd1;
                        6'd56: num = 3'd3;
                        6'd57: num = 3'd2;
                        6'd58: num = 3'd2;
                        6'd59: num = 3'd1;
                        6'd60: num = 3'd2;
                        6'd61: num = 3'd1;
                        6'd62: num = 3'd1;
                        6'd63: num = 3'd0;
                        default: num = 3'd0;
                endcase
        end
endmodule

// zero count of the lane busy bits.
module freeLanes3 (
        input  logic [2:0] emptyStatus,
        output logic [1:0] num
);
        always_comb begin
                case (emptyStatus)
                        3'd0: num = 2'd3;
                        3'd1: num = 2'd2;
                        3'd2: num = 2'd2;
                        3'd3: num = 2'd1;
                        3'd4: num = 2'd2;
                        3'd5: num = 2'd1;
                        3'd6: num = 2'd1;
                        default: num = 2'd0;
                endcase
        end
endmodule

//--- verilog/dispatchStage.sv
`timescale 1ns/1ps

module dispatchStage import rsPkg::*; (
        input  logic             clk,
        input  logic             rst,
        input  logic             inValid,
        input  opT               inOp,
        input  tagT              inDest,
        input  tagT              inSrc1,
        input  logic             inSrc1Rdy,
        input  tagT              inSrc2,
        input  logic             inSrc2Rdy,
        output logic             inStall,
        input  logic [2:0]       freeCount,
        input  logic [LANES-1:0] doneValid,
        input  tagT              doneTag [LANES],
        output logic             allocValid,
        output opT               allocOp,
        output tagT              allocDest,
        output tagT              allocSrc1,
        output logic             allocSrc1Rdy,
        output tagT              allocSrc2,
        output logic             allocSrc2Rdy
);
        holdStateT holdState;
        logic      accept;

        assign allocValid = (holdState == HOLD_FULL) && (freeCount != 3'd0);
        assign inStall    = (holdState == HOLD_FULL) && (freeCount == 3'd0);
        assign accept     = inValid && !inStall; // a strobe under stall is dropped.

        always_ff @(posedge clk) begin
                if (rst) begin
                        holdState <= HOLD_EMPTY;
                end else if (accept) begin
                        holdState <= HOLD_FULL; // refill on the handoff edge too.
                end else if (allocValid) begin
                        holdState <= HOLD_EMPTY;
                end
        end

        // ********************
        // held instruction and wakeup snooping
        // ********************
        always_ff @(posedge clk) begin
                if (accept) begin
                        allocOp      <= inOp;
                        allocDest    <= inDest;
                        allocSrc1    <= inSrc1;
                        allocSrc2    <= inSrc2;
                        allocSrc1Rdy <= inSrc1Rdy || tagHit(inSrc1, doneValid, doneTag);
                        allocSrc2Rdy <= inSrc2Rdy || tagHit(inSrc2, doneValid, doneTag);
                end else begin
                        if (tagHit(allocSrc1, doneValid, doneTag)) begin
                                allocSrc1Rdy <= 1'b1;
                        end
                        if (tagHit(allocSrc2, doneValid, doneTag)) begin
                                allocSrc2Rdy <= 1'b1;
                        end
                end
        end

endmodule

//--- verilog/reservationStation.sv
`timescale 1ns/1ps

module reservationStation import rsPkg::*; (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  allocValid,
        input  opT                    allocOp,
        input  tagT                   allocDest,
        input  tagT                   allocSrc1,
        input  logic                  allocSrc1Rdy,
        input  tagT                   allocSrc2,
        input  logic                  allocSrc2Rdy,
        input  logic [LANES-1:0]      doneValid,
        input  tagT                   doneTag [LANES],
        input  logic [RS_ENTRIES-1:0] issueMask,
        output logic [2:0]            freeCount,
        output logic [RS_ENTRIES-1:0] entValid,
        output logic [RS_ENTRIES-1:0] entReady,
        output opT                    entOp [RS_ENTRIES],
        output tagT                   entDest [RS_ENTRIES]
);
        tagT                   src1 [RS_ENTRIES];
        tagT                   src2 [RS_ENTRIES];
        logic [RS_ENTRIES-1:0] src1Rdy;
        logic [RS_ENTRIES-1:0] src2Rdy;
        logic [RS_ENTRIES-1:0] allocSel;
        logic                  newSrc1Rdy;
        logic                  newSrc2Rdy;

        freeSlots6 uFreeSlots (
                .emptyStatus (entValid),
                .num         (freeCount)
        );

        assign entReady = entValid & src1Rdy & src2Rdy;

        // same-cycle broadcast counts as ready.
        assign newSrc1Rdy = allocSrc1Rdy || tagHit(allocSrc1, doneValid, doneTag);
        assign newSrc2Rdy = allocSrc2Rdy || tagHit(allocSrc2, doneValid, doneTag);

        // one-hot lowest empty entry.
        always_comb begin : pickSlot
                logic found;
                found    = 1'b0;
                allocSel = '0;
                for (int i = 0; i < RS_ENTRIES; i++) begin
                        if (!entValid[i] && !found) begin
                                allocSel[i] = 1'b1;
                                found       = 1'b1;
                        end
                end
        end

        // ********************
        // occupancy
        // ********************
        always_ff @(posedge clk) begin
                if (rst) begin
                        entValid <= '0;
                end else begin
                        for (int i = 0; i < RS_ENTRIES; i++) begin
                                if (allocValid && allocSel[i]) begin
                                        entValid[i] <= 1'b1;
                                end else if (issueMask[i]) begin
                                        entValid[i] <= 1'b0; // freed on the issue edge.
                                end
                        end
                end
        end

        // ********************
        // entry payload and wakeup
        // ********************
        always_ff @(posedge clk) begin
                for (int i = 0; i < RS_ENTRIES; i++) begin
                        if (allocValid && allocSel[i]) begin
                                entOp[i]   <= allocOp;
                                entDest[i] <= allocDest;
                                src1[i]    <= allocSrc1;
                                src2[i]    <= allocSrc2;
                                src1Rdy[i] <= newSrc1Rdy;
                                src2Rdy[i] <= newSrc2Rdy;
                        end else begin
                                if (tagHit(src1[i], doneValid, doneTag)) begin
                                        src1Rdy[i] <= 1'b1;
                                end
                                if (tagHit(src2[i], doneValid, doneTag)) begin
                                        src2Rdy[i] <= 1'b1;
                                end
                        end
                end
        end

endmodule

//--- verilog/issueSelect.sv
`timescale 1ns/1ps

module issueSelect import rsPkg::*; #(
        parameter int mulLatency = 3,
        parameter int divLatency = 6
) (
        input  logic                  clk,
        input  logic                  rst,
        input  logic [RS_ENTRIES-1:0] entValid,
        input  logic [RS_ENTRIES-1:0] entReady,
        input  opT                    entOp [RS_ENTRIES],
        input  tagT                   entDest [RS_ENTRIES],
        output logic [RS_ENTRIES-1:0] issueMask,
        output logic [LANES-1:0]      issueValid,
        output opT                    issueOp [LANES],
        output tagT                   issueTag [LANES],
        output logic [LANES-1:0]      doneValid,
        output tagT                   doneTag [LANES]
);
        localparam int MAX_LAT = (divLatency > mulLatency) ? divLatency : mulLatency;
        localparam int CNT_W   = $clog2(MAX_LAT + 1);

        laneStateT        laneState [LANES];
        logic [CNT_W-1:0] laneCnt [LANES];
        tagT              laneTag [LANES];
        logic [LANES-1:0] laneBusy;
        logic [1:0]       idleCount;

        function automatic logic [CNT_W-1:0] latencyOf(opT op);
                case (op)
                        OP_MUL:  return CNT_W'(mulLatency);
                        OP_DIV:  return CNT_W'(divLatency);
                        default: return CNT_W'(1); // add and sub.
                endcase
        endfunction

        always_comb begin
                for (int l = 0; l < LANES; l++) begin
                        laneBusy[l]  = (laneState[l] == LANE_BUSY);
                        doneValid[l] = laneBusy[l] && (laneCnt[l] == CNT_W'(1));
                        doneTag[l]   = laneTag[l];
                end
        end

        freeLanes3 uFreeLanes (
                .emptyStatus (laneBusy),
                .num         (idleCount)
        );

        // ********************
        // lowest ready entries to lowest idle lanes
        // ********************
        always_comb begin : grant
                logic [1:0] granted;
                logic       placed;
                granted    = 2'd0;
                placed     = 1'b0;
                issueMask  = '0;
                issueValid = '0;
                for (int l = 0; l < LANES; l++) begin
                        issueOp[l]  = OP_ADD;
                        issueTag[l] = '0;
                end
                for (int e = 0; e < RS_ENTRIES; e++) begin
                        if (entValid[e] && entReady[e] && (granted < idleCount)) begin
                                placed = 1'b0;
                                for (int l = 0; l < LANES; l++) begin
                                        if (!laneBusy[l] && !issueValid[l] && !placed) begin
                                                issueValid[l] = 1'b1;
                                                issueOp[l]    = entOp[e];
                                                issueTag[l]   = entDest[e];
                                                placed        = 1'b1;
                                        end
                                end
                                issueMask[e] = 1'b1;
                                granted      = granted + 2'd1;
                        end
                end
        end

        // ********************
        // lane timers
        // ********************
        always_ff @(posedge clk) begin
                for (int l = 0; l < LANES; l++) begin
                        if (rst) begin
                                laneState[l] <= LANE_IDLE;
                        end else if (issueValid[l]) begin
                                laneState[l] <= LANE_BUSY;
                        end else if (doneValid[l]) begin
                                laneState[l] <= LANE_IDLE; // free the cycle after done.
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int l = 0; l < LANES; l++) begin
                        if (issueValid[l]) begin
                                laneCnt[l] <= latencyOf(issueOp[l]);
                                laneTag[l] <= issueTag[l];
                        end else if (laneBusy[l]) begin
                                laneCnt[l] <= laneCnt[l] - CNT_W'(1);
                        end
                end
        end

endmodule

//--- verilog/rsTop.sv
`timescale 1ns/1ps

module rsTop import rsPkg::*; #(
        parameter int mulLatency = 3,
        parameter int divLatency = 6
) (
        input  logic             clk,
        input  logic             rst,
        input  logic             inValid,
        input  opT               inOp,
        input  tagT              inDest,
        input  tagT              inSrc1,
        input  logic             inSrc1Rdy,
        input  tagT              inSrc2,
        input  logic             inSrc2Rdy,
        output logic             inStall,
        output logic [LANES-1:0] issueValid,
        output opT               issueOp [LANES],
        output tagT              issueTag [LANES],
        output logic [LANES-1:0] doneValid,
        output tagT              doneTag [LANES],
        output logic [2:0]       freeCount
);
        logic                  allocValid;
        opT                    allocOp;
        tagT                   allocDest;
        tagT                   allocSrc1;
        logic                  allocSrc1Rdy;
        tagT                   allocSrc2;
        logic                  allocSrc2Rdy;
        logic [RS_ENTRIES-1:0] entValid;
        logic [RS_ENTRIES-1:0] entReady;
        opT                    entOp [RS_ENTRIES];
        tagT                   entDest [RS_ENTRIES];
        logic [RS_ENTRIES-1:0] issueMask;

        dispatchStage uDispatch (.*);  // done broadcast also wakes the holder.

        reservationStation uStation (.*);

        issueSelect #(
                .mulLatency (mulLatency),
                .divLatency (divLatency)
        ) uIssue (.*);

endmodule

//--- verif/tbRs.sv
`timescale 1ns/1ps

module tbRs import rsPkg::*; ();
        localparam int MUL_LAT     = 3;
        localparam int DIV_LAT     = 6;
        localparam int N_MIX       = 60;
        localparam int N_BURST     = 12;
        localparam int NUM_TAGS    = 16;
        localparam int WATCHDOG_NS = ((N_MIX + N_BURST) * DIV_LAT + 300) * 10;

        logic             clk;
        logic             rst;
        logic             inValid;
        opT               inOp;
        tagT              inDest;
        tagT              inSrc1;
        logic             inSrc1Rdy;
        tagT              inSrc2;
        logic             inSrc2Rdy;
        logic             inStall;
        logic [LANES-1:0] issueValid;
        opT               issueOp [LANES];
        tagT              issueTag [LANES];
        logic [LANES-1:0] doneValid;
        tagT              doneTag [LANES];
        logic [2:0]       freeCount;

        integer seed;
        int     cycle, checks, errors, testsRun, errBase;
        int     strobes, dones, liveCount, rsCount;
        logic   stallSeen;
        logic   holdFull;
        tagT    holdTag;
        tagT    lastTag;
        logic   lastValid;

        // ********************
        // scoreboard model
        // ********************
        logic   tagLive [NUM_TAGS];
        logic   tagInRs [NUM_TAGS];
        logic   tagIssued [NUM_TAGS];
        opT     tagOp [NUM_TAGS];
        int     tagIssueCyc [NUM_TAGS];
        tagT    tagSrc [NUM_TAGS][2];
        logic   tagSrcRdy [NUM_TAGS][2];
        int     tagSrcCyc [NUM_TAGS][2]; // cycle of the waking done.
        logic   laneBusyM [LANES];
        tagT    laneTagM [LANES];

        rsTop #(
                .mulLatency (MUL_LAT),
                .divLatency (DIV_LAT)
        ) DUT (.*);

        initial clk = 1'b0;
        always #5 clk = ~clk;

        task automatic checkVal(input string name, input int expVal, input int actVal);
                checks++;
                if (expVal != actVal) begin
                        errors++;
                        $display("ERR t=%0t %s expected %0d actual %0d",
                                 $time, name, expVal, actVal);
                end
        endtask

        function automatic int latencyFor(opT op);
                case (op)
                        OP_MUL:  return MUL_LAT;
                        OP_DIV:  return DIV_LAT;
                        default: return 1;
                endcase
        endfunction

        task automatic retire(input tagT t);
                tagLive[t] = 1'b0;
                liveCount--;
                for (int u = 0; u < NUM_TAGS; u++) begin
                        for (int s = 0; s < 2; s++) begin
                                if (tagLive[u] && !tagSrcRdy[u][s] && tagSrc[u][s] == t) begin
                                        tagSrcRdy[u][s] = 1'b1;
                                        tagSrcCyc[u][s] = cycle;
                                end
                        end
                end
        endtask

        // a live tag left pending, or any tag marked ready.
        task automatic pickSource(output tagT src, output logic rdy);
                tagT cand [$];
                for (int t = 0; t < NUM_TAGS; t++) begin
                        if (tagLive[t]) begin
                                cand.push_back(tagT'(t));
                        end
                end
                src = tagT'($random(seed));
                rdy = 1'b1;
                if (cand.size() > 0 && ($random(seed) & 1)) begin
                        src = cand[($random(seed) & 32'h7fff_ffff) % cand.size()];
                        rdy = 1'b0;
                end
        endtask

        task automatic strobeNew(input int mode);
                tagT  freeList [$];
                tagT  t;
                tagT  s1;
                tagT  s2;
                logic r1;
                logic r2;
                opT   op;
                for (int i = 0; i < NUM_TAGS; i++) begin
                        if (!tagLive[i]) begin
                                freeList.push_back(tagT'(i));
                        end
                end
                if (freeList.size() == 0) begin
                        return;
                end
                t = freeList[($random(seed) & 32'h7fff_ffff) % freeList.size()];
                pickSource(s1, r1);
                pickSource(s2, r2);
                op = opT'(2'($random(seed)));
                if (mode == 2) begin
                        op = OP_DIV; // chain on the previous tag.
                        s1 = lastTag;
                        r1 = !(lastValid && tagLive[lastTag]);
                end
                inValid   = 1'b1;
                inOp      = op;
                inDest    = t;
                inSrc1    = s1;
                inSrc1Rdy = r1;
                inSrc2    = s2;
                inSrc2Rdy = r2;
                tagLive[t]      = 1'b1;
                tagInRs[t]      = 1'b0;
                tagIssued[t]    = 1'b0;
                tagOp[t]        = op;
                tagSrc[t][0]    = s1;
                tagSrc[t][1]    = s2;
                tagSrcRdy[t][0] = r1;
                tagSrcRdy[t][1] = r2;
                tagSrcCyc[t][0] = -1;
                tagSrcCyc[t][1] = -1;
                holdFull  = 1'b1;
                holdTag   = t;
                lastTag   = t;
                lastValid = 1'b1;
                liveCount++;
                strobes++;
        endtask

        // ********************
        // per falling edge check outputs and advance the model
        // ********************
        task automatic stepCycle(input int mode);
                int   nIssued;
                int   inLanes;
                logic alloc;
                logic stallNow;
                logic expDone;
                tagT  t;
                cycle++;
                stallNow = holdFull && (rsCount == RS_ENTRIES);
                checkVal("freeCount", RS_ENTRIES - rsCount, int'(freeCount));
                checkVal("inStall", int'(stallNow), int'(inStall));
                if (inStall) begin
                        stallSeen = 1'b1;
                end
                nIssued = 0;
                for (int l = 0; l < LANES; l++) begin
                        if (issueValid[l]) begin
                                t = issueTag[l];
                                nIssued++;
                                checkVal($sformatf("issueTag[%0d] waiting in station", l), 1,
                                         int'(tagLive[t] && tagInRs[t] && !tagIssued[t]));
                                checkVal($sformatf("lane %0d idle at issue", l), 0,
                                         int'(laneBusyM[l]));
                                checkVal($sformatf("issueOp[%0d]", l), int'(tagOp[t]),
                                         int'(issueOp[l]));
                                for (int s = 0; s < 2; s++) begin
                                        checkVal($sformatf("tag %0d source %0d ready", t, s), 1,
                                                 int'(tagSrcRdy[t][s] && tagSrcCyc[t][s] < cycle));
                                end
                                tagIssued[t]   = 1'b1;
                                tagInRs[t]     = 1'b0;
                                tagIssueCyc[t] = cycle;
                                laneBusyM[l]   = 1'b1;
                                laneTagM[l]    = t;
                        end
                end
                inLanes = 0;
                for (int u = 0; u < NUM_TAGS; u++) begin
                        if (tagLive[u] && tagIssued[u]) begin
                                inLanes++;
                        end
                end
                checkVal("tags in lanes within three", 1, int'(inLanes <= LANES));
                for (int l = 0; l < LANES; l++) begin
                        t       = laneTagM[l];
                        expDone = laneBusyM[l]
                                  && (tagIssueCyc[t] + latencyFor(tagOp[t]) == cycle);
                        checkVal($sformatf("doneValid[%0d]", l), int'(expDone),
                                 int'(doneValid[l]));
                        if (doneValid[l]) begin
                                dones++;
                        end
                        if (expDone) begin
                                checkVal($sformatf("doneTag[%0d]", l), int'(t), int'(doneTag[l]));
                                retire(t);
                                laneBusyM[l] = 1'b0;
                        end
                end
                alloc   = holdFull && (rsCount < RS_ENTRIES);
                rsCount = rsCount - nIssued;
                if (alloc) begin
                        tagInRs[holdTag] = 1'b1;
                        rsCount++;
                        holdFull = 1'b0;
                end
                inValid = 1'b0;
                if (!stallNow && mode == 1 && ($random(seed) & 1)) begin
                        strobeNew(1);
                end else if (!stallNow && mode == 2) begin
                        strobeNew(2);
                end
        endtask

        task automatic reportTest(input string name);
                testsRun++;
                $display("test %-12s strobes %0d done %0d errors %0d",
                         name, strobes, dones, errors - errBase);
                errBase   = errors;
                strobes   = 0;
                dones     = 0;
                stallSeen = 1'b0;
        endtask

        initial begin
                #(WATCHDOG_NS);
                $display("watchdog expired after %0d ns with %0d tags still in flight",
                         WATCHDOG_NS, liveCount);
                $display("TESTBENCH FAILED");
                $finish;
        end

        initial begin
                seed      = 16;
                rst       = 1'b1;
                inValid   = 1'b0;
                inOp      = OP_ADD;
                inDest    = '0;
                inSrc1    = '0;
                inSrc1Rdy = 1'b0;
                inSrc2    = '0;
                inSrc2Rdy = 1'b0;
                cycle     = 0;
                checks    = 0;
                errors    = 0;
                testsRun  = 0;
                errBase   = 0;
                strobes   = 0;
                dones     = 0;
                liveCount = 0;
                rsCount   = 0;
                stallSeen = 1'b0;
                holdFull  = 1'b0;
                holdTag   = '0;
                lastTag   = '0;
                lastValid = 1'b0;
                for (int t = 0; t < NUM_TAGS; t++) begin
                        tagLive[t]   = 1'b0;
                        tagInRs[t]   = 1'b0;
                        tagIssued[t] = 1'b0;
                end
                for (int l = 0; l < LANES; l++) begin
                        laneBusyM[l] = 1'b0;
                        laneTagM[l]  = '0;
                end
                repeat (3) @(negedge clk);
                checkVal("freeCount", RS_ENTRIES, int'(freeCount));
                checkVal("inStall", 0, int'(inStall));
                checkVal("issueValid", 0, int'(issueValid));
                checkVal("doneValid", 0, int'(doneValid));
                rst = 1'b0;
                reportTest("reset");

                while (strobes < N_MIX) begin
                        @(negedge clk);
                        stepCycle(1);
                end
                while (liveCount > 0) begin
                        @(negedge clk);
                        stepCycle(0);
                end
                checkVal("completions in mix", strobes, dones);
                reportTest("random mix");

                lastValid = 1'b0;
                while (strobes < N_BURST) begin
                        @(negedge clk);
                        stepCycle(2);
                end
                while (liveCount > 0) begin
                        @(negedge clk);
                        stepCycle(0);
                end
                checkVal("inStall seen in burst", 1, int'(stallSeen));
                checkVal("completions in burst", strobes, dones);
                reportTest("div burst");

                $display("tests %0d checks %0d errors %0d", testsRun, checks, errors);
                if (errors == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule

//--- build.f
verilog/rsPkg.sv
verilog/slotCounters.sv
verilog/dispatchStage.sv
verilog/reservationStation.sv
verilog/issueSelect.sv
verilog/rsTop.sv
verif/tbRs.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbRs
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

BIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
